/* hdl/l2_req_pkg.sv */
/*
 * Types shared by the L2 request block
 * One-hot transaction ID, request payload struct, channel index
 */

`include "l2_req_defines.svh"

package l2_req_pkg;

   // One-hot ID, bit n belongs to global master n
   typedef logic [`L2_ID_W-1:0] l2_id_t;

   // Payload of one request, 113 bits with the default widths
   typedef struct packed {
      logic [`L2_ADDR_W-1:0]  addr;
      // Low for a write, high for a read
      logic                   wen;
      logic [`L2_DATA_W-1:0]  wdata;
      logic [`L2_BE_W-1:0]    be;
      l2_id_t                 id;
   } l2_req_t;

   // Index of one of the two channels
   typedef logic [$clog2(`L2_N_CH)-1:0] ch_sel_t;

endpackage

/* hdl/l2_request_block.sv */
/*
 * Request side of the shared L2 memory port
 * One round-robin arbiter per channel, then the channel multiplexer
 */

`timescale 1ns/1ps

`include "l2_req_defines.svh"

module l2_request_block
(
   input  logic                                                clk,
   input  logic                                                rst_n_i,

   // Masters, indexed by channel then by master
   input  logic [`L2_N_CH-1:0][`L2_N_PER_CH-1:0]               master_req_i,
   input  l2_req_pkg::l2_req_t [`L2_N_CH-1:0][`L2_N_PER_CH-1:0] master_payload_i,
   output logic [`L2_N_CH-1:0][`L2_N_PER_CH-1:0]               master_gnt_o,

   // Memory request port
   output logic                                                mem_req_o,
   output l2_req_pkg::l2_req_t                                 mem_payload_o,
   input  logic                                                mem_gnt_i,

   // Response valid and its routing to the masters
   input  logic                                                r_valid_i,
   input  l2_req_pkg::l2_id_t                                  r_id_i,
   output logic [`L2_N_MASTER-1:0]                             r_valid_o
);

   import l2_req_pkg::*;

   // Between the arbiters and the multiplexer
   logic [`L2_N_CH-1:0]          ch_req;
   l2_req_t [`L2_N_CH-1:0]       ch_payload;
   logic [`L2_N_CH-1:0]          ch_gnt;

   for (genvar k = 0; k < `L2_N_CH; k++)
   begin : gen_ch_arb
      rr_channel_arbiter
      #(
         .N_MASTER      ( `L2_N_PER_CH          )
      )
      u_arb
      (
         .clk           ( clk                   ),
         .rst_n_i       ( rst_n_i               ),
         .req_i         ( master_req_i[k]       ),
         .payload_i     ( master_payload_i[k]   ),
         .gnt_o         ( master_gnt_o[k]       ),
         .ch_req_o      ( ch_req[k]             ),
         .ch_payload_o  ( ch_payload[k]         ),
         .ch_gnt_i      ( ch_gnt[k]             )
      );
   end

   mem_port_mux u_mux
   (
      .clk              ( clk                   ),
      .rst_n_i          ( rst_n_i               ),

      .ch_req_i         ( ch_req                ),
      .ch_payload_i     ( ch_payload            ),
      .ch_gnt_o         ( ch_gnt                ),

      .mem_req_o        ( mem_req_o             ),
      .mem_payload_o    ( mem_payload_o         ),
      .mem_gnt_i        ( mem_gnt_i             ),

      // Response path is purely combinational
      .r_valid_i        ( r_valid_i             ),
      .r_id_i           ( r_id_i                ),
      .r_valid_o        ( r_valid_o             )
   );

endmodule

/* hdl/mem_port_mux.sv */
/*
 * Two-channel merge onto the single memory request port
 * Alternating preference between the channels
 * Response valid routing by one-hot ID
 */

`timescale 1ns/1ps

`include "l2_req_defines.svh"

module mem_port_mux
(
   input  logic                                     clk,
   input  logic                                     rst_n_i,

   // Channel side, one entry per arbiter
   input  logic [`L2_N_CH-1:0]                      ch_req_i,
   input  l2_req_pkg::l2_req_t [`L2_N_CH-1:0]       ch_payload_i,
   output logic [`L2_N_CH-1:0]                      ch_gnt_o,

   // Memory request port
   output logic                                     mem_req_o,
   output l2_req_pkg::l2_req_t                      mem_payload_o,
   input  logic                                     mem_gnt_i,

   // Response side
   input  logic                                     r_valid_i,
   input  l2_req_pkg::l2_id_t                       r_id_i,
   output logic [`L2_N_MASTER-1:0]                  r_valid_o
);

   import l2_req_pkg::*;

   ch_sel_t    pref_q;
   ch_sel_t    winner;
   logic       accept;

   // A lone requester always wins, the flag only breaks ties
   always_comb
   begin
      if (ch_req_i[0] && ch_req_i[1])
      begin
         winner = pref_q;
      end
      else if (ch_req_i[1])
      begin
         winner = 1'b1;
      end
      else
      begin
         winner = 1'b0;
      end
   end

   assign mem_req_o     = |ch_req_i;
   assign mem_payload_o = ch_payload_i[winner];
   assign accept        = mem_req_o & mem_gnt_i;

   // Memory grant passed back to the winning channel
   always_comb
   begin
      for (int k = 0; k < `L2_N_CH; k++)
      begin
         ch_gnt_o[k] = accept && (winner == ch_sel_t'(k));
      end
   end

   // Preference goes to the channel that was not served
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         pref_q <= '0;
      end
      else if (accept)
      begin
         pref_q <= ~winner;
      end
   end

   // Valid pulse qualified by the one-hot response ID
   assign r_valid_o = {`L2_N_MASTER{r_valid_i}} & r_id_i;

endmodule

/* hdl/rr_channel_arbiter.sv */
/*
 * Round-robin arbiter for the masters of one channel
 * Combinational selection, registered rotating pointer
 */

`timescale 1ns/1ps

`include "l2_req_defines.svh"

module rr_channel_arbiter
#(
   parameter int N_MASTER = `L2_N_PER_CH
)
(
   input  logic                                  clk,
   input  logic                                  rst_n_i,

   // Masters of this channel
   input  logic [N_MASTER-1:0]                   req_i,
   input  l2_req_pkg::l2_req_t [N_MASTER-1:0]    payload_i,
   output logic [N_MASTER-1:0]                   gnt_o,

   // Towards the channel multiplexer
   output logic                                  ch_req_o,
   output l2_req_pkg::l2_req_t                   ch_payload_o,
   input  logic                                  ch_gnt_i
);

   import l2_req_pkg::*;

   localparam int PTR_W = $clog2(N_MASTER);

   logic [PTR_W-1:0]    ptr_q;
   logic [PTR_W-1:0]    winner;
   logic [PTR_W-1:0]    idx;

   // Scan from the pointer upwards with wrap-around.
   // The loop runs backwards so the nearest requester is assigned last.
   always_comb
   begin
      winner = ptr_q;
      idx    = ptr_q;
      for (int i = N_MASTER - 1; i >= 0; i--)
      begin
         // The count is a power of two so the sum wraps by itself
         idx = ptr_q + PTR_W'(i);
         if (req_i[idx])
         begin
            winner = idx;
         end
      end
   end

   assign ch_req_o     = |req_i;
   assign ch_payload_o = payload_i[winner];

   // Grant goes back to the selected master only
   always_comb
   begin
      gnt_o = '0;
      if (ch_req_o && ch_gnt_i)
      begin
         gnt_o[winner] = 1'b1;
      end
   end

   // Pointer moves past the winner after each accepted transfer
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         ptr_q <= '0;
      end
      else if (ch_req_o && ch_gnt_i)
      begin
         ptr_q <= winner + PTR_W'(1);
      end
   end

endmodule

/* include/l2_req_defines.svh */
/*
 * Widths of the L2 request payload fields
 * Channel and master counts of the request block
 */

`ifndef L2_REQ_DEFINES_SVH
`define L2_REQ_DEFINES_SVH

// Payload field widths
`define L2_ADDR_W    32
`define L2_DATA_W    64
`define L2_BE_W      8

// Two channels with the same number of masters each
`define L2_N_CH      2
// Must be a power of two
`define L2_N_PER_CH  4
`define L2_N_MASTER  (`L2_N_CH * `L2_N_PER_CH)

// One bit per master in the transaction ID
`define L2_ID_W      `L2_N_MASTER

`endif

/* run_sim.sh */
#!/bin/sh
# Compile and run the L2 request block testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
   -f tb.f \
   --top-module tb_l2_request_block \
   -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qx "TB PASSED" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

/* tb.f */
+incdir+include
hdl/l2_req_pkg.sv
hdl/rr_channel_arbiter.sv
hdl/mem_port_mux.sv
hdl/l2_request_block.sv
tests/tb_l2_request_block.sv

/* tests/tb_l2_request_block.sv */
/*
 * Directed testbench for the L2 request block
 * Pass-through, round-robin, channel alternation, back-pressure, response routing
 */

`timescale 1ns/1ps

`include "l2_req_defines.svh"

module tb_l2_request_block;

   import l2_req_pkg::*;

   localparam int TIMEOUT_CYCLES = 2000;
   localparam logic [31:0] SEED  = 32'h57f8_8e27;

   logic                                            clk;
   logic                                            rst_n_i;
   logic [`L2_N_CH-1:0][`L2_N_PER_CH-1:0]           master_req_i;
   l2_req_t [`L2_N_CH-1:0][`L2_N_PER_CH-1:0]        master_payload_i;
   logic [`L2_N_CH-1:0][`L2_N_PER_CH-1:0]           master_gnt_o;
   logic                                            mem_req_o;
   l2_req_t                                         mem_payload_o;
   logic                                            mem_gnt_i;
   logic                                            r_valid_i;
   l2_id_t                                          r_id_i;
   logic [`L2_N_MASTER-1:0]                         r_valid_o;

   int            cycle_cnt = 0;
   int            check_cnt = 0;
   int            error_cnt = 0;
   logic [31:0]   rng_state = SEED;

   l2_request_block uut
   (
      .clk              ( clk               ),
      .rst_n_i          ( rst_n_i           ),
      .master_req_i     ( master_req_i      ),
      .master_payload_i ( master_payload_i  ),
      .master_gnt_o     ( master_gnt_o      ),
      .mem_req_o        ( mem_req_o         ),
      .mem_payload_o    ( mem_payload_o     ),
      .mem_gnt_i        ( mem_gnt_i         ),
      .r_valid_i        ( r_valid_i         ),
      .r_id_i           ( r_id_i            ),
      .r_valid_o        ( r_valid_o         )
   );

   initial
   begin
      clk = 1'b0;
   end

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // Random payload whose ID is one-hot at the master's global position
   function automatic l2_req_t rand_payload(int ch, int m);
      l2_req_t     p;
      logic [31:0] r;
      r       = next_rand();
      p.addr  = next_rand();
      p.wen   = r[0];
      p.wdata = {next_rand(), next_rand()};
      p.be    = r[15:8];
      p.id    = 8'(1) << (ch * `L2_N_PER_CH + m);
      return p;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic idle_inputs();
      master_req_i     = '0;
      master_payload_i = '0;
      mem_gnt_i        = 1'b0;
      r_valid_i        = 1'b0;
      r_id_i           = '0;
   endtask

   task automatic apply_reset();
      idle_inputs();
      rst_n_i = 1'b0;
      repeat (10) @(posedge clk);
      #2;
      rst_n_i = 1'b1;
   endtask

   task automatic check_value(string name, logic [127:0] exp, logic [127:0] act);
      check_cnt++;
      if (act !== exp)
      begin
         error_cnt++;
         $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
      end
   endtask

   // Expects the master at global index idx to win this cycle
   task automatic check_winner(string name, int idx);
      check_value({name, " mem_req"}, 128'(1'b1), 128'(mem_req_o));
      check_value({name, " gnt"}, 128'(8'(1) << idx), 128'(master_gnt_o));
      check_value({name, " payload"},
                  128'(master_payload_i[idx / `L2_N_PER_CH][idx % `L2_N_PER_CH]),
                  128'(mem_payload_o));
   endtask

   task automatic test_pass_through();
      apply_reset();
      mem_gnt_i = 1'b1;
      #5;
      check_value("pass_through idle mem_req", 128'(1'b0), 128'(mem_req_o));
      check_value("pass_through idle gnt", 128'(0), 128'(master_gnt_o));
      for (int g = 0; g < `L2_N_MASTER; g++)
      begin
         next_cycle();
         master_req_i = '0;
         master_req_i[g / `L2_N_PER_CH][g % `L2_N_PER_CH] = 1'b1;
         master_payload_i[g / `L2_N_PER_CH][g % `L2_N_PER_CH] =
            rand_payload(g / `L2_N_PER_CH, g % `L2_N_PER_CH);
         #5;
         check_winner("pass_through", g);
      end
      next_cycle();
      idle_inputs();
   endtask

   task automatic test_round_robin();
      int exp_seq [5] = '{0, 1, 2, 3, 0};
      apply_reset();
      for (int m = 0; m < `L2_N_PER_CH; m++)
      begin
         master_payload_i[0][m] = rand_payload(0, m);
      end
      master_req_i[0] = '1;
      mem_gnt_i       = 1'b1;
      for (int i = 0; i < 5; i++)
      begin
         #5;
         check_winner("round_robin", exp_seq[i]);
         next_cycle();
      end
      idle_inputs();
   endtask

   task automatic test_channel_alternation();
      int exp_seq [4] = '{1, 6, 1, 6};
      apply_reset();
      master_payload_i[0][1] = rand_payload(0, 1);
      master_payload_i[1][2] = rand_payload(1, 2);
      master_req_i[0][1]     = 1'b1;
      master_req_i[1][2]     = 1'b1;
      mem_gnt_i              = 1'b1;
      for (int i = 0; i < 4; i++)
      begin
         #5;
         check_winner("channel_alternation", exp_seq[i]);
         next_cycle();
      end
      idle_inputs();
   endtask

   task automatic test_back_pressure();
      int      exp_seq [5] = '{0, 7, 2, 7, 0};
      l2_req_t held;
      apply_reset();
      master_payload_i[0][0] = rand_payload(0, 0);
      master_payload_i[0][2] = rand_payload(0, 2);
      master_payload_i[1][3] = rand_payload(1, 3);
      master_req_i[0][0]     = 1'b1;
      master_req_i[0][2]     = 1'b1;
      master_req_i[1][3]     = 1'b1;
      held                   = '0;
      // Memory stalls, nothing may move
      for (int i = 0; i < 5; i++)
      begin
         #5;
         check_value("back_pressure mem_req", 128'(1'b1), 128'(mem_req_o));
         check_value("back_pressure gnt", 128'(0), 128'(master_gnt_o));
         check_value("back_pressure payload", 128'(master_payload_i[0][0]),
                     128'(mem_payload_o));
         if (i > 0)
         begin
            check_value("back_pressure stable", 128'(held), 128'(mem_payload_o));
         end
         held = mem_payload_o;
         next_cycle();
      end
      mem_gnt_i = 1'b1;
      for (int i = 0; i < 5; i++)
      begin
         #5;
         check_winner("back_pressure", exp_seq[i]);
         next_cycle();
      end
      idle_inputs();
   endtask

   task automatic test_response_routing();
      logic [31:0] r;
      idle_inputs();
      for (int i = 0; i < 8; i++)
      begin
         r         = next_rand();
         r_id_i    = 8'(1) << r[2:0];
         r_valid_i = 1'b1;
         #5;
         check_value("response_routing valid", 128'(r_id_i), 128'(r_valid_o));
         next_cycle();
         r_valid_i = 1'b0;
         #5;
         check_value("response_routing idle", 128'(0), 128'(r_valid_o));
         next_cycle();
      end
      idle_inputs();
   endtask

   initial
   begin
      apply_reset();
      test_pass_through();
      test_round_robin();
      test_channel_alternation();
      test_back_pressure();
      test_response_routing();
      $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
      if (error_cnt == 0)
      begin
         $display("TB PASSED");
      end
      else
      begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial
   begin
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
   end

endmodule
